/* verilog/sort_pkg.sv */
// Shared widths, comparator tables and stream types for the chunk sorter RTL and its testbench
package sort_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int SORT_SIZE = 8;
    localparam int NETWORK_DEPTH = 6;
    localparam int LEN_WIDTH = 4;
    localparam int PAIRS_PER_LAYER = SORT_SIZE / 2;

    // Batcher odd-even merge sort for eight inputs, 19 compare-exchanges in six layers
    // Entries past PAIR_COUNT in a row are never used
    localparam int PAIR_COUNT [NETWORK_DEPTH] = '{4, 4, 2, 4, 2, 3};

    localparam int PAIR_LO [NETWORK_DEPTH][PAIRS_PER_LAYER] = '{
        '{0, 2, 4, 6},
        '{0, 1, 4, 5},
        '{1, 5, 0, 0},
        '{0, 1, 2, 3},
        '{2, 3, 0, 0},
        '{1, 3, 5, 0}
    };

    localparam int PAIR_HI [NETWORK_DEPTH][PAIRS_PER_LAYER] = '{
        '{1, 3, 5, 7},
        '{2, 3, 6, 7},
        '{2, 6, 0, 0},
        '{4, 5, 6, 7},
        '{4, 5, 0, 0},
        '{2, 4, 6, 0}
    };

    typedef logic [WORD_WIDTH-1:0] sort_word_t;
    typedef logic [LEN_WIDTH-1:0] chunk_len_t;

    // Slot 0 is the lowest word after sorting
    typedef sort_word_t [SORT_SIZE-1:0] sort_block_t;

    typedef struct packed {
        sort_block_t data;
        chunk_len_t  len;
    } sort_chunk_t;

    typedef struct packed {
        sort_word_t data;
        chunk_len_t len;
    } stream_beat_t;

endpackage

/* verilog/chunk_collector.sv */
// Input stage of the sorter that packs streamed words into a padded eight-word block
`timescale 1ns/1ps

module chunk_collector import sort_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  stream_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output sort_chunk_t  block,
    output logic         block_valid,
    input  logic         block_ready
);

    sort_block_t                    data_q;
    chunk_len_t                     len_q;
    logic [$clog2(SORT_SIZE)-1:0]   wr_idx;
    logic                           block_valid_q;
    logic                           accept;
    logic                           chunk_done;

    // A finished block blocks the input only until the network claims it
    assign in_ready = ~block_valid_q | block_ready;
    assign accept = in_valid & in_ready;
    assign chunk_done = accept & (chunk_len_t'(wr_idx) == in_beat.len - chunk_len_t'(1));

    assign block.data = data_q;
    assign block.len = len_q;
    assign block_valid = block_valid_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx <= '0;
            block_valid_q <= 1'b0;
        end else begin
            if (chunk_done) begin
                wr_idx <= '0;
            end else if (accept) begin
                wr_idx <= wr_idx + 1'b1;
            end

            // A chunk may complete in the very cycle the previous block is taken
            if (chunk_done) begin
                block_valid_q <= 1'b1;
            end else if (block_ready) begin
                block_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            // Padding uses all ones so it sorts above every real word
            if (wr_idx == '0) begin
                for (int i = 1; i < SORT_SIZE; i++) begin
                    data_q[i] <= '1;
                end
            end
            data_q[wr_idx] <= in_beat.data;
        end
        if (chunk_done) begin
            len_q <= in_beat.len;
        end
    end

endmodule

/* verilog/batcher_network_8.sv */
// Pipelined eight-input Batcher odd-even merge network that sorts one block per cycle
`timescale 1ns/1ps

module batcher_network_8 import sort_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  sort_chunk_t block,
    input  logic        block_valid,
    output logic        block_ready,
    output sort_chunk_t sorted,
    output logic        sorted_valid,
    input  logic        sorted_ready
);

    // Layer inputs, compare-exchange results and the registers between layers
    sort_chunk_t              stage_src [NETWORK_DEPTH];
    sort_chunk_t              stage_d [NETWORK_DEPTH];
    sort_chunk_t              stage_q [NETWORK_DEPTH];
    logic [NETWORK_DEPTH-1:0] stage_valid;
    logic                     stall;

    // The whole pipe freezes when the final layer holds an unclaimed block.
    // Bubbles are not squeezed out, which keeps the control to one signal
    assign stall = stage_valid[NETWORK_DEPTH-1] & ~sorted_ready;
    assign block_ready = ~stall;

    assign stage_src[0] = block;

    genvar l;
    generate
        for (l = 0; l < NETWORK_DEPTH; l++) begin : g_layer
            if (l > 0) begin : g_chain
                assign stage_src[l] = stage_q[l-1];
            end

            // Pairs inside one layer never share a slot, so each reads the layer input directly
            always_comb begin
                stage_d[l] = stage_src[l];
                for (int p = 0; p < PAIR_COUNT[l]; p++) begin
                    if (stage_src[l].data[PAIR_HI[l][p]] < stage_src[l].data[PAIR_LO[l][p]]) begin
                        stage_d[l].data[PAIR_LO[l][p]] = stage_src[l].data[PAIR_HI[l][p]];
                        stage_d[l].data[PAIR_HI[l][p]] = stage_src[l].data[PAIR_LO[l][p]];
                    end
                end
            end
        end
    endgenerate

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid <= {stage_valid[NETWORK_DEPTH-2:0], block_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            for (int i = 0; i < NETWORK_DEPTH; i++) begin
                stage_q[i] <= stage_d[i];
            end
        end
    end

    assign sorted = stage_q[NETWORK_DEPTH-1];
    assign sorted_valid = stage_valid[NETWORK_DEPTH-1];

endmodule

/* verilog/chunk_serializer.sv */
// Output stage of the sorter that streams the first len words of each sorted block
`timescale 1ns/1ps

module chunk_serializer import sort_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  sort_chunk_t  sorted,
    input  logic         sorted_valid,
    output logic         sorted_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    output logic         out_last,
    input  logic         out_ready
);

    typedef enum logic {
        st_idle,
        st_emit
    } ser_state_t;

    ser_state_t                   state_q;
    sort_block_t                  buf_q;
    chunk_len_t                   len_q;
    logic [$clog2(SORT_SIZE)-1:0] rd_idx;
    logic                         beat_done;
    logic                         last_done;
    logic                         load;

    assign out_valid = (state_q == st_emit);
    assign out_last = out_valid & (chunk_len_t'(rd_idx) == len_q - chunk_len_t'(1));
    assign out_beat.data = buf_q[rd_idx];
    assign out_beat.len = len_q;

    assign beat_done = out_valid & out_ready;
    assign last_done = beat_done & out_last;

    // Taking a new block while the last word leaves avoids a gap between chunks
    assign sorted_ready = (state_q == st_idle) | last_done;
    assign load = sorted_valid & sorted_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            rd_idx <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (load) begin
                        state_q <= st_emit;
                        rd_idx <= '0;
                    end
                end
                st_emit: begin
                    if (load) begin
                        rd_idx <= '0;
                    end else if (last_done) begin
                        state_q <= st_idle;
                    end else if (beat_done) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            buf_q <= sorted.data;
            len_q <= sorted.len;
        end
    end

endmodule

/* verilog/batcher_sorter_serial.sv */
// Top level of the streaming chunk sorter, from serial input words to sorted serial output
`timescale 1ns/1ps

module batcher_sorter_serial import sort_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  stream_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    output logic         out_last,
    input  logic         out_ready
);

    sort_chunk_t block;
    logic        block_valid;
    logic        block_ready;
    sort_chunk_t sorted;
    logic        sorted_valid;
    logic        sorted_ready;

    chunk_collector u_collector (
        .clock       (clock),
        .arst_n      (arst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .block       (block),
        .block_valid (block_valid),
        .block_ready (block_ready)
    );

    batcher_network_8 u_network (
        .clock        (clock),
        .arst_n       (arst_n),
        .block        (block),
        .block_valid  (block_valid),
        .block_ready  (block_ready),
        .sorted       (sorted),
        .sorted_valid (sorted_valid),
        .sorted_ready (sorted_ready)
    );

    chunk_serializer u_serializer (
        .clock        (clock),
        .arst_n       (arst_n),
        .sorted       (sorted),
        .sorted_valid (sorted_valid),
        .sorted_ready (sorted_ready),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_ready    (out_ready)
    );

endmodule

/* dv/clock_gen.sv */
// Testbench clock and reset source, a 100 ns clock with reset held low for the first 10 cycles
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset is released on a falling edge, away from the rising edge the DUT samples on
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

/* dv/tb_batcher_sorter.sv */
// Testbench for the streaming chunk sorter, random chunks checked against a sorting model
`timescale 1ns/1ps

module tb_batcher_sorter import sort_pkg::*; ();

    localparam int BEAT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int RESET_TIMEOUT = 20;

    logic         clock;
    logic         arst_n;
    stream_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_last;
    logic         out_ready;

    integer       seed;
    bit           throttle_out;
    bit           random_gaps;
    bit           timed_out;
    int           error_count;
    int           tests_run;
    int           tests_failed;

    // Expected output beats, in the order the sink must see them
    sort_word_t   exp_data [$];
    chunk_len_t   exp_len [$];
    logic         exp_last [$];

    clock_gen u_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    batcher_sorter_serial UUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    task automatic compare_word(input string name, input sort_word_t exp, input sort_word_t act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_len(input string name, input chunk_len_t exp, input chunk_len_t act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    // Inputs change on the falling edge, and out_ready is picked here for the coming cycle
    task automatic advance_cycle();
        @(negedge clock);
        if (throttle_out) begin
            out_ready = ($unsigned($random(seed)) % 2) == 0;
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // Insertion sort of the real words only, so padding never reaches the model
    task automatic queue_expected(input sort_block_t words, input chunk_len_t len);
        sort_word_t ordered [SORT_SIZE];
        sort_word_t key;
        int         j;
        for (int i = 0; i < int'(len); i++) begin
            ordered[i] = words[i];
        end
        for (int i = 1; i < int'(len); i++) begin
            key = ordered[i];
            j = i - 1;
            while (j >= 0 && ordered[j] > key) begin
                ordered[j + 1] = ordered[j];
                j--;
            end
            ordered[j + 1] = key;
        end
        for (int i = 0; i < int'(len); i++) begin
            exp_data.push_back(ordered[i]);
            exp_len.push_back(len);
            exp_last.push_back(i == int'(len) - 1);
        end
    endtask

    function automatic sort_block_t random_block(input int ones_per_eight);
        sort_block_t words;
        for (int i = 0; i < SORT_SIZE; i++) begin
            if (int'($unsigned($random(seed)) % 8) < ones_per_eight) begin
                words[i] = '1;
            end else begin
                words[i] = sort_word_t'($random(seed));
            end
        end
        return words;
    endfunction

    function automatic chunk_len_t random_len(input int min_len, input int max_len);
        return chunk_len_t'(min_len + int'($unsigned($random(seed)) % (max_len - min_len + 1)));
    endfunction

    // Called on a falling edge, returns on the falling edge after the beat was taken
    task automatic send_beat(input stream_beat_t beat);
        int waited;
        waited = 0;
        in_beat = beat;
        in_valid = 1'b1;
        #10;
        while (!in_ready && !timed_out) begin
            if (waited >= BEAT_TIMEOUT) begin
                $display("Timeout: in_ready stayed low for %0d cycles", BEAT_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                advance_cycle();
                #10;
                waited++;
            end
        end
        advance_cycle();
    endtask

    task automatic send_chunk(input sort_block_t words, input chunk_len_t len,
                              input bit hold_valid);
        stream_beat_t beat;
        queue_expected(words, len);
        for (int i = 0; i < int'(len) && !timed_out; i++) begin
            if (random_gaps && ($unsigned($random(seed)) % 2) == 0) begin
                in_valid = 1'b0;
                advance_cycle();
            end
            beat.data = words[i];
            beat.len = len;
            send_beat(beat);
        end
        if (!hold_valid) begin
            in_valid = 1'b0;
            advance_cycle();
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_data.size() > 0 && !timed_out) begin
            if (waited >= DRAIN_TIMEOUT) begin
                $display("Timeout: %0d expected output words never arrived", exp_data.size());
                timed_out = 1'b1;
            end else begin
                advance_cycle();
                waited++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count != errors_before || timed_out) begin
            tests_failed++;
        end
        $display("Test %s done with %0d errors", name, error_count - errors_before);
    endtask

    task automatic verify_reset();
        int waited;
        int errors_before;
        errors_before = error_count;
        waited = 0;
        // The first rising edge under reset settles every register before the checks start
        @(posedge clock);
        do begin
            advance_cycle();
            #10;
            compare_bit("out_valid", 1'b0, out_valid);
            compare_bit("out_last", 1'b0, out_last);
            compare_bit("in_ready", 1'b1, in_ready);
            waited++;
        end while (!arst_n && waited < RESET_TIMEOUT);
        if (!arst_n) begin
            $display("Timeout: reset was still asserted after %0d cycles", RESET_TIMEOUT);
            timed_out = 1'b1;
        end
        // The idle state must hold for a cycle after reset too
        advance_cycle();
        #10;
        compare_bit("out_valid", 1'b0, out_valid);
        compare_bit("in_ready", 1'b1, in_ready);
        advance_cycle();
        report_test("reset_state", errors_before);
    endtask

    task automatic sort_chunks(input string name, input int count, input int min_len,
                               input int max_len, input int ones_per_eight,
                               input bit hold_valid);
        int errors_before;
        errors_before = error_count;
        for (int c = 0; c < count && !timed_out; c++) begin
            // The first short chunk is all ones, so every real word ties with the padding
            if (ones_per_eight > 0 && c == 0) begin
                send_chunk(random_block(8), random_len(min_len, max_len), hold_valid);
            end else begin
                send_chunk(random_block(ones_per_eight), random_len(min_len, max_len),
                           hold_valid);
            end
        end
        in_valid = 1'b0;
        wait_for_drain();
        report_test(name, errors_before);
    endtask

    always @(negedge clock) begin
        #10;
        if (arst_n && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("Output word %h arrived when the model expected nothing", out_beat.data);
                error_count++;
            end else begin
                compare_word("out_beat.data", exp_data.pop_front(), out_beat.data);
                compare_len("out_beat.len", exp_len.pop_front(), out_beat.len);
                compare_bit("out_last", exp_last.pop_front(), out_last);
            end
        end
    end

    initial begin
        seed = 32'h3c53;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        throttle_out = 1'b0;
        random_gaps = 1'b0;
        timed_out = 1'b0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;

        verify_reset();
        if (!timed_out) begin
            sort_chunks("full_chunks", 20, 8, 8, 0, 1'b0);
        end
        if (!timed_out) begin
            sort_chunks("short_chunks", 20, 1, 7, 2, 1'b0);
        end
        // Short chunks held back to back keep several blocks inside the network
        if (!timed_out) begin
            sort_chunks("back_to_back", 16, 1, 3, 1, 1'b1);
        end
        if (!timed_out) begin
            throttle_out = 1'b1;
            random_gaps = 1'b1;
            sort_chunks("back_pressure", 30, 1, 8, 1, 1'b0);
            throttle_out = 1'b0;
            random_gaps = 1'b0;
        end

        // A few idle cycles let any stray output word show up in the monitor
        for (int i = 0; i < 20 && !timed_out; i++) begin
            advance_cycle();
        end

        $display("Tests run %0d, tests failed %0d, errors %0d, timeout %0d",
                 tests_run, tests_failed, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* batcher_sort.f */
verilog/sort_pkg.sv
verilog/chunk_collector.sv
verilog/batcher_network_8.sv
verilog/chunk_serializer.sv
verilog/batcher_sorter_serial.sv
dv/clock_gen.sv
dv/tb_batcher_sorter.sv

/* Makefile */
TOP := tb_batcher_sorter
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f batcher_sort.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
